// ==== design/icache_params.svh ====
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry
`define ICACHE_LINES      32
`define VICTIM_WAYS       2
`define LINE_BYTES        8

// prefetch engine
`define SEND_BUFFER_SIZE  4
`define PREFETCH_DEPTH    7    // blocks after the fetch block

// address split is tag | index | offset
`define FETCH_ADDR_BITS   16
`define OFFSET_BITS       3
`define INDEX_BITS        5
`define MEM_TAG_BITS      4

`endif

// ==== design/icache_pkg.sv ====
`include "icache_params.svh"

package icache_pkg;

    // byte address into the 64 KiB instruction space
    typedef logic [`FETCH_ADDR_BITS-1:0] fetch_addr_t;

    // address without byte offset, also the victim tag
    typedef logic [`FETCH_ADDR_BITS-`OFFSET_BITS-1:0] block_addr_t;

    typedef logic [`FETCH_ADDR_BITS-`OFFSET_BITS-`INDEX_BITS-1:0] line_tag_t;
    typedef logic [`INDEX_BITS-1:0] line_idx_t;

    typedef logic [8*`LINE_BYTES-1:0] line_data_t;   // one cache line
    typedef logic [31:0] instr_t;

    // bus transaction tag, zero means none
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    typedef enum logic [1:0] {
        BUS_NONE = 2'h0,
        BUS_LOAD = 2'h1
    } bus_command_t;

endpackage

// ==== design/icache_fill_if.sv ====
`timescale 1ns/1ps

// completed memory fill, send buffer to line array
interface icache_fill_if;
    import icache_pkg::*;

    logic        fill_valid;   // single cycle per returned line
    block_addr_t fill_block;
    line_data_t  fill_data;

    modport source (
        output fill_valid,
        output fill_block,
        output fill_data
    );

    modport sink (
        input fill_valid,
        input fill_block,
        input fill_data
    );

endinterface

// ==== design/icache_victim_if.sv ====
`timescale 1ns/1ps

// line array to victim cache: lookups, evictions, promotions
interface icache_victim_if;
    import icache_pkg::*;

    block_addr_t fetch_block;
    block_addr_t probe_block;

    logic        fetch_hit;
    line_data_t  fetch_data;
    logic        probe_hit;
    line_data_t  probe_data;

    // line leaving the array
    logic        evict_valid;
    block_addr_t evict_block;
    line_data_t  evict_data;
    logic        promote_valid;   // probe hit moves into the array

    modport array (
        output fetch_block, probe_block,
        output evict_valid, evict_block, evict_data, promote_valid,
        input  fetch_hit, fetch_data, probe_hit, probe_data
    );

    modport victim (
        input  fetch_block, probe_block,
        input  evict_valid, evict_block, evict_data, promote_valid,
        output fetch_hit, fetch_data, probe_hit, probe_data
    );

endinterface

// ==== design/icache_victim.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_victim (
    input  logic            clock,
    input  logic            reset,
    icache_victim_if.victim victim
);
    import icache_pkg::*;

    localparam int WAY_BITS = $clog2(`VICTIM_WAYS);

    logic [`VICTIM_WAYS-1:0] way_valid;
    block_addr_t             way_block [`VICTIM_WAYS];
    line_data_t              way_data  [`VICTIM_WAYS];

    logic [WAY_BITS-1:0] lru;         // next way to replace
    logic [WAY_BITS-1:0] fetch_way;
    logic [WAY_BITS-1:0] probe_way;
    logic [WAY_BITS-1:0] fill_way;

    // fully associative match, both lookups in parallel
    always_comb begin
        victim.fetch_hit = 1'b0;
        victim.probe_hit = 1'b0;
        fetch_way = '0;
        probe_way = '0;
        for (int i = 0; i < `VICTIM_WAYS; i++) begin
            if (way_valid[i] && (way_block[i] == victim.fetch_block)) begin
                victim.fetch_hit = 1'b1;
                fetch_way = WAY_BITS'(i);
            end
            if (way_valid[i] && (way_block[i] == victim.probe_block)) begin
                victim.probe_hit = 1'b1;
                probe_way = WAY_BITS'(i);
            end
        end
    end

    assign victim.fetch_data = way_data[fetch_way];
    assign victim.probe_data = way_data[probe_way];

    // a promotion swaps into the way it came from
    assign fill_way = victim.promote_valid ? probe_way : lru;

    always_ff @(posedge clock) begin
        if (reset) begin
            way_valid <= '0;
            lru <= '0;
        end else if (victim.promote_valid || victim.evict_valid) begin
            way_valid[fill_way] <= victim.evict_valid;   // empty array line frees the way
            way_block[fill_way] <= victim.evict_block;
            way_data[fill_way]  <= victim.evict_data;
            if (victim.evict_valid) begin
                lru <= fill_way + 1'b1;   // point past the way just written
            end else begin
                lru <= fill_way;          // reuse the emptied way first
            end
        end
    end

endmodule

// ==== design/icache_array.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_array (
    input  logic                    clock,
    input  logic                    reset,
    input  icache_pkg::fetch_addr_t fetch_addr,
    output icache_pkg::instr_t      fetch_data,
    output logic                    fetch_valid,
    input  icache_pkg::block_addr_t probe_block,
    output logic                    probe_present,
    icache_fill_if.sink             fill,
    icache_victim_if.array          victim
);
    import icache_pkg::*;

    logic [`ICACHE_LINES-1:0] line_valid;
    line_tag_t                line_tag  [`ICACHE_LINES];
    line_data_t               line_data [`ICACHE_LINES];

    block_addr_t fetch_block;
    line_tag_t   fetch_tag;
    line_idx_t   fetch_idx;
    line_tag_t   probe_tag;
    line_idx_t   probe_idx;
    line_tag_t   fill_tag;
    line_idx_t   fill_idx;

    logic       fetch_array_hit;
    logic       probe_array_hit;
    logic       promote;
    line_data_t fetch_line;

    assign fetch_block = fetch_addr[`FETCH_ADDR_BITS-1:`OFFSET_BITS];

    assign {fetch_tag, fetch_idx} = fetch_block;
    assign {probe_tag, probe_idx} = probe_block;
    assign {fill_tag, fill_idx}   = fill.fill_block;

    assign fetch_array_hit = line_valid[fetch_idx] && (line_tag[fetch_idx] == fetch_tag);
    assign probe_array_hit = line_valid[probe_idx] && (line_tag[probe_idx] == probe_tag);

    // fetch side, array first, then victim
    assign victim.fetch_block = fetch_block;
    assign fetch_valid = fetch_array_hit || victim.fetch_hit;
    assign fetch_line  = fetch_array_hit ? line_data[fetch_idx] : victim.fetch_data;
    assign fetch_data  = fetch_addr[`OFFSET_BITS-1]
                       ? fetch_line[$bits(line_data_t)-1 -: $bits(instr_t)]
                       : fetch_line[$bits(instr_t)-1:0];

    // prefetch probe
    assign victim.probe_block = probe_block;
    assign probe_present = probe_array_hit || victim.probe_hit;

    // fills own the evict channel, a promotion waits a cycle
    assign promote = victim.probe_hit && !probe_array_hit && !fill.fill_valid;
    assign victim.promote_valid = promote;

    always_comb begin
        if (fill.fill_valid) begin
            // same block refilled, nothing to push out
            victim.evict_valid = line_valid[fill_idx] && (line_tag[fill_idx] != fill_tag);
            victim.evict_block = {line_tag[fill_idx], fill_idx};
            victim.evict_data  = line_data[fill_idx];
        end else begin
            victim.evict_valid = promote && line_valid[probe_idx];
            victim.evict_block = {line_tag[probe_idx], probe_idx};
            victim.evict_data  = line_data[probe_idx];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill.fill_valid) begin
            line_valid[fill_idx] <= 1'b1;
            line_tag[fill_idx]   <= fill_tag;
            line_data[fill_idx]  <= fill.fill_data;
        end else if (promote) begin
            // swap half, victim side takes the old line
            line_valid[probe_idx] <= 1'b1;
            line_tag[probe_idx]   <= probe_tag;
            line_data[probe_idx]  <= victim.probe_data;
        end
    end

endmodule

// ==== design/icache_prefetch.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_prefetch (
    input  logic                     clock,
    input  logic                     reset,
    input  icache_pkg::fetch_addr_t  fetch_addr,
    input  logic                     fetch_valid,
    output icache_pkg::block_addr_t  probe_block,
    input  logic                     probe_present,
    icache_fill_if.source            fill,
    output icache_pkg::bus_command_t mem_command,
    output icache_pkg::fetch_addr_t  mem_addr,
    input  icache_pkg::mem_tag_t     mem_response,
    input  icache_pkg::mem_tag_t     mem_tag,
    input  icache_pkg::line_data_t   mem_data
);
    import icache_pkg::*;

    localparam int          PTR_BITS     = $clog2(`SEND_BUFFER_SIZE);
    localparam block_addr_t DEPTH        = block_addr_t'(`PREFETCH_DEPTH);
    localparam fetch_addr_t WINDOW_BYTES = fetch_addr_t'(`PREFETCH_DEPTH * `LINE_BYTES);

    // send buffer, circular
    logic [`SEND_BUFFER_SIZE-1:0] ent_valid;
    logic [`SEND_BUFFER_SIZE-1:0] ent_done;
    block_addr_t                  ent_block [`SEND_BUFFER_SIZE];
    mem_tag_t                     ent_tag   [`SEND_BUFFER_SIZE];   // zero until issued
    logic [PTR_BITS-1:0]          send_ptr;
    logic [PTR_BITS-1:0]          tail_ptr;

    fetch_addr_t last_addr;
    block_addr_t stream;        // next block to look at
    block_addr_t fetch_block;
    block_addr_t lag;
    block_addr_t probe_pos;

    logic                redirect;
    logic                behind;
    logic                active;
    logic                in_flight;
    logic                tail_free;
    logic                head_waiting;
    logic                accept;
    logic                match;
    logic [PTR_BITS-1:0] match_idx;

    assign fetch_block = fetch_addr[`FETCH_ADDR_BITS-1:`OFFSET_BITS];

    // fetch left the window around the previous address
    assign redirect = (fetch_addr - last_addr) > WINDOW_BYTES;

    // fetch ran past the stream, pick up at the fetch block
    assign lag       = fetch_block - stream;
    assign behind    = (lag != '0) && !lag[$bits(block_addr_t)-1];
    assign probe_pos = behind ? fetch_block : stream;
    assign active    = (probe_pos - fetch_block) <= DEPTH;

    // idle stream probes the fetch block so victim hits get promoted
    assign probe_block = active ? probe_pos : fetch_block;

    assign tail_free    = !ent_valid[tail_ptr] || ent_done[tail_ptr];
    assign head_waiting = ent_valid[send_ptr] && !ent_done[send_ptr]
                       && (ent_tag[send_ptr] == '0);
    assign accept       = head_waiting && (mem_response != '0);

    assign mem_command = head_waiting ? BUS_LOAD : BUS_NONE;
    assign mem_addr    = {ent_block[send_ptr], {`OFFSET_BITS{1'b0}}};

    always_comb begin
        match = 1'b0;
        match_idx = '0;
        in_flight = 1'b0;
        for (int i = 0; i < `SEND_BUFFER_SIZE; i++) begin
            if (ent_valid[i] && !ent_done[i]) begin
                if ((ent_tag[i] != '0) && (ent_tag[i] == mem_tag)) begin
                    match = 1'b1;
                    match_idx = PTR_BITS'(i);
                end
                if (ent_block[i] == probe_pos) begin
                    in_flight = 1'b1;   // already queued, skip it
                end
            end
        end
    end

    // returning line, written by the array on this edge
    assign fill.fill_valid = match;
    assign fill.fill_block = ent_block[match_idx];
    assign fill.fill_data  = mem_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            ent_valid <= '0;
            ent_done  <= '0;
            send_ptr  <= '0;
            tail_ptr  <= '0;
            stream    <= '0;
            last_addr <= '0;
        end else begin
            last_addr <= fetch_addr;
            if (redirect) begin
                stream    <= fetch_valid ? fetch_block + 1'b1 : fetch_block;
                ent_valid <= '0;
                ent_done  <= '0;
                send_ptr  <= '0;
                tail_ptr  <= '0;
                // a refused load stays on the bus through the flush
                if (head_waiting && !accept) begin
                    ent_valid[0] <= 1'b1;
                    ent_block[0] <= ent_block[send_ptr];
                    ent_tag[0]   <= '0;
                    tail_ptr     <= PTR_BITS'(1);
                end
            end else begin
                if (active) begin
                    if (probe_present || in_flight) begin
                        stream <= probe_pos + 1'b1;
                    end else if (tail_free) begin
                        ent_valid[tail_ptr] <= 1'b1;
                        ent_done[tail_ptr]  <= 1'b0;
                        ent_block[tail_ptr] <= probe_pos;
                        ent_tag[tail_ptr]   <= '0;
                        tail_ptr <= tail_ptr + 1'b1;
                        stream   <= probe_pos + 1'b1;
                    end
                end
                if (accept) begin
                    ent_tag[send_ptr] <= mem_response;   // memory's tag for this load
                    send_ptr <= send_ptr + 1'b1;
                end
                if (match) begin
                    ent_done[match_idx] <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/icache.sv ====
`timescale 1ns/1ps

module icache (
    input  logic                     clock,
    input  logic                     reset,
    input  icache_pkg::fetch_addr_t  fetch_addr,
    output icache_pkg::instr_t       fetch_data,
    output logic                     fetch_valid,
    output icache_pkg::bus_command_t mem_command,
    output icache_pkg::fetch_addr_t  mem_addr,
    input  icache_pkg::mem_tag_t     mem_response,
    input  icache_pkg::mem_tag_t     mem_tag,
    input  icache_pkg::line_data_t   mem_data
);
    import icache_pkg::*;

    block_addr_t probe_block;     // prefetch stream position
    logic        probe_present;

    icache_fill_if   fill_bus ();
    icache_victim_if victim_bus ();

    icache_array array_i (
        .clock         (clock),
        .reset         (reset),
        .fetch_addr    (fetch_addr),
        .fetch_data    (fetch_data),
        .fetch_valid   (fetch_valid),
        .probe_block   (probe_block),
        .probe_present (probe_present),
        .fill          (fill_bus.sink),
        .victim        (victim_bus.array)
    );

    icache_victim victim_i (
        .clock  (clock),
        .reset  (reset),
        .victim (victim_bus.victim)
    );

    icache_prefetch prefetch_i (
        .clock         (clock),
        .reset         (reset),
        .fetch_addr    (fetch_addr),
        .fetch_valid   (fetch_valid),
        .probe_block   (probe_block),
        .probe_present (probe_present),
        .fill          (fill_bus.source),
        .mem_command   (mem_command),
        .mem_addr      (mem_addr),
        .mem_response  (mem_response),
        .mem_tag       (mem_tag),
        .mem_data      (mem_data)
    );

endmodule

// ==== testbench/icache_assert.sv ====
`timescale 1ns/1ps

module icache_assert (
    input logic                     clock,
    input logic                     reset,
    input icache_pkg::bus_command_t mem_command,
    input icache_pkg::fetch_addr_t  mem_addr,
    input icache_pkg::mem_tag_t     mem_response
);
    import icache_pkg::*;

    // bus idle on the first edge out of reset
    idle_after_reset: assert property (@(posedge clock) reset |=> mem_command == BUS_NONE)
        else $error("mem_command not idle after reset");

    // a refused load holds command and address
    hold_on_refusal: assert property (@(posedge clock) disable iff (reset)
        (mem_command == BUS_LOAD && mem_response == '0)
        |=> (mem_command == BUS_LOAD && $stable(mem_addr)))
        else $error("load changed while refused");

    // a load carries a known line aligned address
    load_addr_valid: assert property (@(posedge clock) disable iff (reset)
        mem_command == BUS_LOAD |-> !$isunknown(mem_addr) && mem_addr[2:0] == 3'b000)
        else $error("load address unknown or not aligned to a line");

endmodule

bind icache icache_assert assert_i (.*);

// ==== testbench/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    logic         clock = 1'b0;
    logic         reset;
    fetch_addr_t  fetch_addr;
    instr_t       fetch_data;
    logic         fetch_valid;
    bus_command_t mem_command;
    fetch_addr_t  mem_addr;
    mem_tag_t     mem_response;
    mem_tag_t     mem_tag;
    line_data_t   mem_data;

    line_data_t  mem_lines [8192];   // whole 64 KiB space by line
    mem_tag_t    pend_tag [$];
    block_addr_t pend_block [$];
    int          pend_due [$];
    fetch_addr_t accepted [$];       // addresses memory took

    int          errors = 0;
    int          cycle = 0;
    int          refuse_count = 0;
    int          idle_cycles = 0;
    logic        reverse_order = 1'b0;
    logic        refusing = 1'b0;
    mem_tag_t    next_tag = 4'd1;
    fetch_addr_t refused_addr;

    icache dut_i (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle++;
        if (cycle >= 4000) begin
            $display("run stopped at cycle limit, %0d errors so far", errors);
            $display("tests failed");
            $finish;
        end
    end

    // tagged memory answering 1 ns after the edge
    always @(posedge clock) begin
        #1;
        mem_tag = '0;
        mem_response = '0;
        idle_cycles++;
        if (!reverse_order && pend_tag.size() > 0 && pend_due[0] <= cycle) begin
            mem_tag  = pend_tag.pop_front();
            mem_data = mem_lines[pend_block.pop_front()];
            void'(pend_due.pop_front());
        end else if (reverse_order && pend_tag.size() > 0 && idle_cycles > 10) begin
            mem_tag  = pend_tag.pop_back();   // newest first
            mem_data = mem_lines[pend_block.pop_back()];
            void'(pend_due.pop_back());
        end
        if (refusing) begin
            compare_bus(mem_command, BUS_LOAD, "mem_command");
            compare_addr(mem_addr, refused_addr, "mem_addr");
        end
        if (mem_command == BUS_LOAD) begin
            if (refuse_count > 0) begin
                if (!refusing) refused_addr = mem_addr;
                refusing = 1'b1;
                refuse_count--;
            end else begin
                refusing = 1'b0;
                mem_response = next_tag;
                accepted.push_back(mem_addr);
                pend_tag.push_back(next_tag);
                pend_block.push_back(mem_addr[15:3]);
                pend_due.push_back(cycle + 3);
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                idle_cycles = 0;
            end
        end
    end

    function automatic instr_t model_word(fetch_addr_t addr);
        line_data_t line;
        line = mem_lines[addr[15:3]];
        return addr[2] ? line[63:32] : line[31:0];
    endfunction

    function automatic int count_loads(fetch_addr_t addr);
        int n;
        n = 0;
        foreach (accepted[i]) if (accepted[i] == addr) n++;
        return n;
    endfunction

    task automatic compare_instr(instr_t got, instr_t exp, string name);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bus(bus_command_t got, bus_command_t exp, string name);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(fetch_addr_t got, fetch_addr_t exp, string name);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic set_fetch(fetch_addr_t addr);
        @(posedge clock);
        #1 fetch_addr = addr;
    endtask

    // miss path waits for the line to show up
    task automatic fetch_and_wait(fetch_addr_t addr);
        int n;
        n = 0;
        set_fetch(addr);
        @(negedge clock);
        while (!fetch_valid && n < 300) begin
            @(negedge clock);
            n++;
        end
        if (!fetch_valid) report_failure($sformatf("fetch of %h never became valid", addr));
        else compare_instr(fetch_data, model_word(addr), "fetch_data");
    endtask

    task automatic check_hit(fetch_addr_t addr);
        set_fetch(addr);
        @(negedge clock);
        if (!fetch_valid) report_failure($sformatf("fetch of %h missed, hit expected", addr));
        else compare_instr(fetch_data, model_word(addr), "fetch_data");
    endtask

    task automatic walk_hits(int first, int last);
        for (int a = first; a <= last; a += 4) check_hit(fetch_addr_t'(a));
    endtask

    // no load on the bus and none outstanding for a while
    task automatic wait_quiet();
        int n;
        int quiet;
        n = 0;
        quiet = 0;
        while (quiet < 12 && n < 400) begin
            @(negedge clock);
            n++;
            if (mem_command == BUS_NONE && pend_tag.size() == 0) quiet++;
            else quiet = 0;
        end
        if (quiet < 12) report_failure("bus never went quiet");
    endtask

    task automatic test_reset();
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
        @(negedge clock);
        compare_bus(mem_command, BUS_NONE, "mem_command");
        if (fetch_valid !== 1'b0) report_failure("fetch_valid not low right after reset");
    endtask

    task automatic test_cold_miss();
        accepted.delete();
        fetch_and_wait(16'h1000);
        if (count_loads(16'h1000) != 1) report_failure("cold miss block not loaded once");
        wait_quiet();
    endtask

    task automatic test_sequential();
        accepted.delete();
        fetch_and_wait(16'h2000);
        wait_quiet();
        foreach (accepted[i]) begin
            if (accepted[i] < 16'h2000 || accepted[i] > 16'h2038)
                report_failure($sformatf("load of %h outside the window", accepted[i]));
            if (count_loads(accepted[i]) != 1)
                report_failure($sformatf("block %h loaded twice", accepted[i]));
        end
        walk_hits(32'h2004, 32'h203c);
        wait_quiet();
        for (int a = 32'h2000; a <= 32'h2038; a += 8)
            if (count_loads(fetch_addr_t'(a)) != 1)
                report_failure($sformatf("block %h not loaded exactly once", a));
    endtask

    task automatic test_victim();
        fetch_and_wait(16'h3000);
        wait_quiet();
        check_hit(16'h3038);
        wait_quiet();
        fetch_and_wait(16'h3100);   // same indexes with a new tag
        wait_quiet();
        accepted.delete();
        check_hit(16'h303c);
        wait_quiet();
        check_hit(16'h3038);        // promoted line now served by the array
        if (count_loads(16'h3038) != 0) report_failure("victim line was loaded again");
    endtask

    task automatic test_backpressure();
        accepted.delete();
        refuse_count = 5;
        fetch_and_wait(16'h4000);
        if (refuse_count != 0) report_failure("memory never refused a load");
        if (count_loads(16'h4000) != 1) report_failure("refused load not accepted once");
        wait_quiet();
    endtask

    task automatic test_reverse_redirect();
        int n;
        reverse_order = 1'b1;
        fetch_and_wait(16'h5000);
        wait_quiet();
        walk_hits(32'h5000, 32'h503c);
        set_fetch(16'h6000);
        n = 0;
        while (pend_tag.size() < 4 && n < 100) begin
            @(negedge clock);
            n++;
        end
        if (pend_tag.size() < 4) report_failure("loads before redirect not accepted");
        fetch_and_wait(16'h6800);   // far jump while old tags are still out
        wait_quiet();
        walk_hits(32'h6800, 32'h683c);
        reverse_order = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        fetch_addr = '0;
        mem_response = '0;
        mem_tag = '0;
        mem_data = '0;
        void'($urandom(78));
        foreach (mem_lines[i]) mem_lines[i] = {$urandom, $urandom};
        test_reset();
        test_cold_miss();
        test_sequential();
        test_victim();
        test_backpressure();
        test_reverse_redirect();
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+design
design/icache_pkg.sv
design/icache_fill_if.sv
design/icache_victim_if.sv
design/icache_victim.sv
design/icache_array.sv
design/icache_prefetch.sv
design/icache.sv
testbench/icache_assert.sv
testbench/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module icache_tb \
    -f sources.f -o icache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    cat build.log
    exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1
